//--- logic/kbd_ps2_pkg.sv
package kbd_ps2_pkg;

	// One key event from the PS/2 decoder
	typedef struct packed {
		logic       valid;
		logic       pressed;
		logic       extended;
		logic [7:0] scan;
	} ps2_event_t;

	typedef logic [8:0] scan_addr_t;  // {extended, scan}

	localparam logic [7:0] SCAN_CAPSLOCK = 8'h58;

endpackage

//--- logic/kbd_mac_pkg.sv
package kbd_mac_pkg;

	// Host command bytes
	typedef enum logic [7:0] {
		CMD_NONE    = 8'h00,
		CMD_INQUIRY = 8'h10,
		CMD_INSTANT = 8'h14,
		CMD_MODEL   = 8'h16,
		CMD_TEST    = 8'h36
	} mac_cmd_e;

	typedef struct packed {
		logic       keypad;  // Needs the keypad prefix byte
		logic [6:0] code;
	} mac_key_t;

	localparam logic [7:0] REPLY_NULL     = 8'h7b;
	localparam logic [7:0] REPLY_MODEL    = 8'h03;
	localparam logic [7:0] REPLY_TEST_ACK = 8'h7d;
	localparam logic [7:0] REPLY_KEYPAD   = 8'h79;

	// Pace timer defaults in clk cycles
	localparam int TICK_SHORT_DEFAULT = 'hfff;
	localparam int TICK_LONG_DEFAULT  = 'h3fffff;

endpackage

//--- logic/mac_pace_timer.sv
module mac_pace_timer #(
	parameter int tick_short_count = kbd_mac_pkg::TICK_SHORT_DEFAULT,
	parameter int tick_long_count  = kbd_mac_pkg::TICK_LONG_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	input  logic restart,
	output logic tick_short,
	output logic tick_long
);

	localparam int cnt_w = $clog2(tick_long_count + 1);

	logic [cnt_w-1:0] count;

	assign tick_short = count == cnt_w'(tick_short_count);
	assign tick_long  = count == cnt_w'(tick_long_count);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;  // New host command
		end else if (!tick_long) begin
			count <= count + 1'b1;  // Holds at the timeout
		end
	end

endmodule

//--- logic/scan_to_mac.sv
module scan_to_mac (
	input  logic                   clk,
	input  logic                   reset,
	input  kbd_ps2_pkg::ps2_event_t ps2_key,
	output logic                   xlat_valid,
	output logic                   xlat_pressed,
	output logic                   xlat_extended,
	output logic [7:0]             xlat_scan,
	output kbd_mac_pkg::mac_key_t  xlat_key
);

	import kbd_ps2_pkg::*;
	import kbd_mac_pkg::*;

	scan_addr_t addr;
	mac_key_t   key;

	assign addr = {ps2_key.extended, ps2_key.scan};

	always_comb begin
		case (addr)
			9'h00d: key = '{1'b0, 7'h61};  // Tab
			9'h00e: key = '{1'b0, 7'h65};  // Backtick
			9'h011: key = '{1'b0, 7'h6f};  // Left alt as command
			9'h012: key = '{1'b0, 7'h71};  // Left shift
			9'h015: key = '{1'b0, 7'h19};  // q
			9'h016: key = '{1'b0, 7'h25};  // 1
			9'h01a: key = '{1'b0, 7'h0d};  // z
			9'h01b: key = '{1'b0, 7'h03};  // s
			9'h01c: key = '{1'b0, 7'h01};  // a
			9'h01d: key = '{1'b0, 7'h1b};  // w
			9'h01e: key = '{1'b0, 7'h27};  // 2
			9'h021: key = '{1'b0, 7'h11};  // c
			9'h022: key = '{1'b0, 7'h0f};  // x
			9'h023: key = '{1'b0, 7'h05};  // d
			9'h024: key = '{1'b0, 7'h1d};  // e
			9'h025: key = '{1'b0, 7'h2b};  // 4
			9'h026: key = '{1'b0, 7'h29};  // 3
			9'h029: key = '{1'b0, 7'h63};  // Space
			9'h02a: key = '{1'b0, 7'h13};  // v
			9'h02b: key = '{1'b0, 7'h07};  // f
			9'h02c: key = '{1'b0, 7'h23};  // t
			9'h02d: key = '{1'b0, 7'h1f};  // r
			9'h02e: key = '{1'b0, 7'h2f};  // 5
			9'h031: key = '{1'b0, 7'h5b};  // n
			9'h032: key = '{1'b0, 7'h17};  // b
			9'h033: key = '{1'b0, 7'h09};  // h
			9'h034: key = '{1'b0, 7'h0b};  // g
			9'h035: key = '{1'b0, 7'h21};  // y
			9'h036: key = '{1'b0, 7'h2d};  // 6
			9'h03a: key = '{1'b0, 7'h5d};  // m
			9'h03b: key = '{1'b0, 7'h4d};  // j
			9'h03c: key = '{1'b0, 7'h41};  // u
			9'h03d: key = '{1'b0, 7'h35};  // 7
			9'h03e: key = '{1'b0, 7'h39};  // 8
			9'h041: key = '{1'b0, 7'h57};  // Comma
			9'h042: key = '{1'b0, 7'h51};  // k
			9'h043: key = '{1'b0, 7'h45};  // i
			9'h044: key = '{1'b0, 7'h3f};  // o
			9'h045: key = '{1'b0, 7'h3b};  // 0
			9'h046: key = '{1'b0, 7'h33};  // 9
			9'h049: key = '{1'b0, 7'h5f};  // Period
			9'h04a: key = '{1'b0, 7'h59};  // Slash
			9'h04b: key = '{1'b0, 7'h4b};  // l
			9'h04c: key = '{1'b0, 7'h53};  // Semicolon
			9'h04d: key = '{1'b0, 7'h47};  // p
			9'h04e: key = '{1'b0, 7'h37};  // Minus
			9'h052: key = '{1'b0, 7'h4f};  // Quote
			9'h054: key = '{1'b0, 7'h43};  // Open bracket
			9'h055: key = '{1'b0, 7'h31};  // Equals
			9'h058: key = '{1'b0, 7'h73};  // Caps lock
			9'h059: key = '{1'b0, 7'h71};  // Right shift
			9'h05a: key = '{1'b0, 7'h49};  // Return
			9'h05b: key = '{1'b0, 7'h3d};  // Close bracket
			9'h05d: key = '{1'b0, 7'h55};  // Backslash
			9'h061: key = '{1'b0, 7'h71};  // ISO extra key as shift
			9'h066: key = '{1'b0, 7'h67};  // Backspace
			9'h069: key = '{1'b1, 7'h27};  // KP 1
			9'h06b: key = '{1'b1, 7'h2d};  // KP 4
			9'h06c: key = '{1'b1, 7'h33};  // KP 7
			9'h070: key = '{1'b1, 7'h25};  // KP 0
			9'h071: key = '{1'b1, 7'h03};  // KP point
			9'h072: key = '{1'b1, 7'h29};  // KP 2
			9'h073: key = '{1'b1, 7'h2f};  // KP 5
			9'h074: key = '{1'b1, 7'h31};  // KP 6
			9'h075: key = '{1'b1, 7'h37};  // KP 8
			9'h079: key = '{1'b1, 7'h0d};  // KP plus
			9'h07a: key = '{1'b1, 7'h2b};  // KP 3
			9'h07b: key = '{1'b1, 7'h1d};  // KP minus
			9'h07c: key = '{1'b1, 7'h05};  // KP star
			9'h07d: key = '{1'b1, 7'h39};  // KP 9
			9'h111: key = '{1'b0, 7'h6f};  // Right alt as command
			9'h11f: key = '{1'b0, 7'h75};  // Windows key as option
			9'h14a: key = '{1'b1, 7'h1b};  // KP divide
			9'h15a: key = '{1'b1, 7'h19};  // KP enter
			9'h16b: key = '{1'b1, 7'h0d};  // Arrow left
			9'h171: key = '{1'b1, 7'h0f};  // Delete as keypad clear
			9'h172: key = '{1'b1, 7'h11};  // Arrow down
			9'h174: key = '{1'b1, 7'h05};  // Arrow right
			9'h175: key = '{1'b1, 7'h1b};  // Arrow up
			default: key = '{1'b0, REPLY_NULL[6:0]};
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			xlat_valid <= 1'b0;
		end else begin
			xlat_valid <= ps2_key.valid;
		end
	end

	// Event fields ride along with the looked-up key
	always_ff @(posedge clk) begin
		xlat_pressed  <= ps2_key.pressed;
		xlat_extended <= ps2_key.extended;
		xlat_scan     <= ps2_key.scan;
		xlat_key      <= key;
	end

endmodule

//--- logic/key_buffer.sv
module key_buffer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  xlat_valid,
	input  logic                  xlat_pressed,
	input  logic                  xlat_extended,
	input  logic [7:0]            xlat_scan,
	input  kbd_mac_pkg::mac_key_t xlat_key,
	input  logic                  key_pop,
	input  logic                  key_flush,
	output logic                  key_pending,
	output logic                  key_prefix,
	output logic [7:0]            key_byte,
	output logic                  capslock
);

	import kbd_ps2_pkg::*;

	logic is_caps;
	logic suppress;
	logic load;

	assign is_caps  = !xlat_extended && xlat_scan == SCAN_CAPSLOCK;
	assign suppress = is_caps && capslock;  // Mac sees caps only as a lock
	assign load     = xlat_valid && !key_pending && !suppress && !key_pop && !key_flush;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			key_pending <= 1'b0;
			key_prefix  <= 1'b0;
			capslock    <= 1'b0;
		end else begin
			if (xlat_valid && is_caps && xlat_pressed) begin
				capslock <= !capslock;
			end
			if (key_flush) begin
				key_pending <= 1'b0;
				key_prefix  <= 1'b0;
			end else if (key_pop) begin
				if (key_prefix) begin
					key_prefix <= 1'b0;  // Code byte goes out next
				end else begin
					key_pending <= 1'b0;
				end
			end else if (load) begin
				key_pending <= 1'b1;
				key_prefix  <= xlat_key.keypad;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			key_byte <= {!xlat_pressed, xlat_key.code};  // Top bit set on release
		end
	end

endmodule

//--- logic/mac_responder.sv
module mac_responder (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] host_data,
	input  logic       host_strobe,
	input  logic       tick_short,
	input  logic       tick_long,
	input  logic       key_pending,
	input  logic       key_prefix,
	input  logic [7:0] key_byte,
	output logic       key_pop,
	output logic       key_flush,
	output logic [7:0] reply_data,
	output logic       reply_strobe
);

	import kbd_mac_pkg::*;

	mac_cmd_e host_cmd;
	mac_cmd_e cmd;
	logic     inquiry_wait;
	logic     key_reply;
	logic     fixed_reply;

	always_comb begin
		case (host_data)
			CMD_INQUIRY, CMD_INSTANT, CMD_MODEL, CMD_TEST: host_cmd = mac_cmd_e'(host_data);
			default: host_cmd = CMD_NONE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmd <= CMD_NONE;
		end else if (host_strobe) begin
			cmd <= host_cmd;  // Replaces any command still in flight
		end
	end

	// Inquiry may only answer once the short tick has passed
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			inquiry_wait <= 1'b0;
		end else if (host_strobe || reply_strobe) begin
			inquiry_wait <= 1'b0;
		end else if (tick_short) begin
			inquiry_wait <= cmd == CMD_INQUIRY;
		end
	end

	assign key_reply = (cmd == CMD_INSTANT && tick_short)
		|| (inquiry_wait && (tick_long || key_pending));
	assign fixed_reply = (cmd == CMD_MODEL || cmd == CMD_TEST) && tick_short;

	assign reply_strobe = key_reply || fixed_reply;
	assign key_pop      = key_reply && key_pending;
	assign key_flush    = host_strobe && (host_cmd == CMD_MODEL || host_cmd == CMD_TEST);

	always_comb begin
		if (cmd == CMD_TEST) begin
			reply_data = REPLY_TEST_ACK;
		end else if (cmd == CMD_MODEL) begin
			reply_data = REPLY_MODEL;
		end else if (key_pending && key_prefix) begin
			reply_data = REPLY_KEYPAD;
		end else if (key_pending) begin
			reply_data = key_byte;
		end else begin
			reply_data = REPLY_NULL;  // Nothing to report
		end
	end

endmodule

//--- logic/ps2_mac_kbd.sv
module ps2_mac_kbd #(
	parameter int tick_short_count = kbd_mac_pkg::TICK_SHORT_DEFAULT,
	parameter int tick_long_count  = kbd_mac_pkg::TICK_LONG_DEFAULT
) (
	input  logic                    clk,
	input  logic                    reset,
	input  kbd_ps2_pkg::ps2_event_t ps2_key,
	input  logic [7:0]              host_data,
	input  logic                    host_strobe,
	output logic [7:0]              reply_data,
	output logic                    reply_strobe,
	output logic                    capslock
);

	import kbd_mac_pkg::*;

	logic       xlat_valid;
	logic       xlat_pressed;
	logic       xlat_extended;
	logic [7:0] xlat_scan;
	mac_key_t   xlat_key;
	logic       key_pending;
	logic       key_prefix;
	logic [7:0] key_byte;
	logic       key_pop;
	logic       key_flush;
	logic       tick_short;
	logic       tick_long;

	mac_pace_timer #(
		.tick_short_count(tick_short_count),
		.tick_long_count (tick_long_count)
	) pace_i (
		.clk       (clk),
		.reset     (reset),
		.restart   (host_strobe),
		.tick_short(tick_short),
		.tick_long (tick_long)
	);

	scan_to_mac xlat_i (
		.clk          (clk),
		.reset        (reset),
		.ps2_key      (ps2_key),
		.xlat_valid   (xlat_valid),
		.xlat_pressed (xlat_pressed),
		.xlat_extended(xlat_extended),
		.xlat_scan    (xlat_scan),
		.xlat_key     (xlat_key)
	);

	key_buffer buf_i (
		.clk          (clk),
		.reset        (reset),
		.xlat_valid   (xlat_valid),
		.xlat_pressed (xlat_pressed),
		.xlat_extended(xlat_extended),
		.xlat_scan    (xlat_scan),
		.xlat_key     (xlat_key),
		.key_pop      (key_pop),
		.key_flush    (key_flush),
		.key_pending  (key_pending),
		.key_prefix   (key_prefix),
		.key_byte     (key_byte),
		.capslock     (capslock)
	);

	mac_responder resp_i (
		.clk         (clk),
		.reset       (reset),
		.host_data   (host_data),
		.host_strobe (host_strobe),
		.tick_short  (tick_short),
		.tick_long   (tick_long),
		.key_pending (key_pending),
		.key_prefix  (key_prefix),
		.key_byte    (key_byte),
		.key_pop     (key_pop),
		.key_flush   (key_flush),
		.reply_data  (reply_data),
		.reply_strobe(reply_strobe)
	);

endmodule

//--- bench/ps2_mac_kbd_tb.sv
module ps2_mac_kbd_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import kbd_ps2_pkg::*;

	localparam int TICK_SHORT = 8;
	localparam int TICK_LONG  = 64;
	localparam int TIMEOUT    = 200;
	localparam int KEY_AT     = 20;  // Wait cycle that carries the late key

	// Reply latencies counted from the cycle after the host strobe
	localparam logic [7:0] SHORT_LAT = TICK_SHORT + 1;
	localparam logic [7:0] PEND_LAT  = TICK_SHORT + 2;
	localparam logic [7:0] LONG_LAT  = TICK_LONG + 1;
	localparam logic [7:0] WAIT_LAT  = KEY_AT + 2;

	localparam logic [1:0] KEY_NONE   = 2'd0;
	localparam logic [1:0] KEY_BEFORE = 2'd1;
	localparam logic [1:0] KEY_DURING = 2'd2;

	typedef struct packed {
		logic [127:0] name;
		logic [1:0]   key_mode;
		logic [8:0]   key;  // {extended, scan}
		logic         pressed;
		logic [7:0]   lost_scan;  // Second press sent while the first is pending
		logic [7:0]   cmd;
		logic [7:0]   exp_reply;
		logic         exp_caps;
		logic [7:0]   exp_latency;
	} row_t;

	logic       clk;
	logic       reset;
	ps2_event_t ps2_key;
	logic [7:0] host_data;
	logic       host_strobe;
	logic [7:0] reply_data;
	logic       reply_strobe;
	logic       capslock;

	row_t rows[$];

	ps2_mac_kbd #(
		.tick_short_count(TICK_SHORT),
		.tick_long_count (TICK_LONG)
	) dut_i (
		.clk         (clk),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.host_data   (host_data),
		.host_strobe (host_strobe),
		.reply_data  (reply_data),
		.reply_strobe(reply_strobe),
		.capslock    (capslock)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic add_row(input logic [127:0] name, input logic [1:0] mode,
		input logic [8:0] key, input logic pressed, input logic [7:0] lost,
		input logic [7:0] cmd, input logic [7:0] reply, input logic caps,
		input logic [7:0] latency);
		row_t row;
		row = '{name, mode, key, pressed, lost, cmd, reply, caps, latency};
		rows.push_back(row);
	endtask

	task automatic build_table();
		add_row("model",           KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h16, 8'h03, 1'b0, SHORT_LAT);
		add_row("test",            KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h36, 8'h7d, 1'b0, SHORT_LAT);
		add_row("instant_empty",   KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h14, 8'h7b, 1'b0, SHORT_LAT);
		add_row("inquiry_timeout", KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h10, 8'h7b, 1'b0, LONG_LAT);
		add_row("a_press",         KEY_BEFORE, 9'h01c, 1'b1, 8'h00, 8'h10, 8'h01, 1'b0, PEND_LAT);
		add_row("a_release",       KEY_BEFORE, 9'h01c, 1'b0, 8'h00, 8'h10, 8'h81, 1'b0, PEND_LAT);
		add_row("key_in_wait",     KEY_DURING, 9'h01c, 1'b1, 8'h00, 8'h10, 8'h01, 1'b0, WAIT_LAT);
		add_row("lost_key",        KEY_BEFORE, 9'h01c, 1'b0, 8'h32, 8'h10, 8'h81, 1'b0, PEND_LAT);
		add_row("lost_check",      KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h14, 8'h7b, 1'b0, SHORT_LAT);
		add_row("instant_key",     KEY_BEFORE, 9'h023, 1'b1, 8'h00, 8'h14, 8'h05, 1'b0, SHORT_LAT);
		add_row("kp1_prefix",      KEY_BEFORE, 9'h069, 1'b1, 8'h00, 8'h10, 8'h79, 1'b0, PEND_LAT);
		add_row("kp1_code",        KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h10, 8'h27, 1'b0, PEND_LAT);
		add_row("up_prefix",       KEY_BEFORE, 9'h175, 1'b1, 8'h00, 8'h10, 8'h79, 1'b0, PEND_LAT);
		add_row("up_code",         KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h10, 8'h1b, 1'b0, PEND_LAT);
		add_row("caps_on",         KEY_BEFORE, 9'h058, 1'b1, 8'h00, 8'h10, 8'h73, 1'b1, PEND_LAT);
		add_row("caps_release",    KEY_BEFORE, 9'h058, 1'b0, 8'h00, 8'h10, 8'h7b, 1'b1, LONG_LAT);
		add_row("caps_off",        KEY_BEFORE, 9'h058, 1'b1, 8'h00, 8'h10, 8'h7b, 1'b0, LONG_LAT);
		add_row("flush_model",     KEY_BEFORE, 9'h01c, 1'b1, 8'h00, 8'h16, 8'h03, 1'b0, SHORT_LAT);
		add_row("flush_check",     KEY_NONE,   9'h000, 1'b0, 8'h00, 8'h14, 8'h7b, 1'b0, SHORT_LAT);
	endtask

	task automatic check_value(input logic [127:0] name, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		if (expected !== actual) begin
			$display("FAIL %0s %0s expected %h actual %h", name, what, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// All stimulus tasks start and end 2 ns after a rising edge
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_key(input logic [8:0] key, input logic pressed);
		ps2_key.valid    = 1'b1;
		ps2_key.pressed  = pressed;
		ps2_key.extended = key[8];
		ps2_key.scan     = key[7:0];
		idle(1);
		ps2_key = '0;
	endtask

	task automatic send_command(input logic [7:0] cmd);
		host_data   = cmd;
		host_strobe = 1'b1;
		idle(1);
		host_strobe = 1'b0;
		host_data   = 8'h00;
	endtask

	task automatic await_reply(input row_t row, output logic [7:0] data,
		output logic caps, output logic [7:0] latency);
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		while (!got) begin
			n++;
			if (row.key_mode == KEY_DURING && n == KEY_AT) begin
				ps2_key.valid    = 1'b1;
				ps2_key.pressed  = row.pressed;
				ps2_key.extended = row.key[8];
				ps2_key.scan     = row.key[7:0];
			end else begin
				ps2_key = '0;
			end
			@(negedge clk);  // Outputs settled mid cycle
			if (reply_strobe) begin
				got  = 1'b1;
				data = reply_data;
				caps = capslock;
			end else if (n >= TIMEOUT) begin
				$display("Timeout: no reply strobe for %0s within %0d cycles", row.name, TIMEOUT);
				$display("Test FAILED");
				$fatal(1);
			end
			idle(1);
		end
		ps2_key = '0;
		latency = n[7:0];
	endtask

	initial begin
		row_t       row;
		logic [7:0] data;
		logic       caps;
		logic [7:0] latency;
		void'($urandom(4));
		reset       = 1'b1;
		ps2_key     = '0;
		host_data   = 8'h00;
		host_strobe = 1'b0;
		build_table();
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			row = rows[i];
			idle($urandom_range(1, 4));
			if (row.key_mode == KEY_BEFORE) begin
				send_key(row.key, row.pressed);
				idle(3);  // Translation plus buffer load
				if (row.lost_scan != 8'h00) begin
					send_key({1'b0, row.lost_scan}, 1'b1);
					idle(3);
				end
			end
			send_command(row.cmd);
			await_reply(row, data, caps, latency);
			check_value(row.name, "reply", row.exp_reply, data);
			check_value(row.name, "capslock", {7'd0, row.exp_caps}, {7'd0, caps});
			check_value(row.name, "latency", row.exp_latency, latency);
		end
		$display("Test OK");
		$finish;
	end

endmodule

//--- ps2_mac_kbd.f
logic/kbd_ps2_pkg.sv
logic/kbd_mac_pkg.sv
logic/mac_pace_timer.sv
logic/scan_to_mac.sv
logic/key_buffer.sv
logic/mac_responder.sv
logic/ps2_mac_kbd.sv
bench/ps2_mac_kbd_tb.sv

//--- Bender.yml
package:
  name: ps2_mac_kbd

sources:
  - logic/kbd_ps2_pkg.sv
  - logic/kbd_mac_pkg.sv
  - logic/mac_pace_timer.sv
  - logic/scan_to_mac.sv
  - logic/key_buffer.sv
  - logic/mac_responder.sv
  - logic/ps2_mac_kbd.sv
  - target: test
    files:
      - bench/ps2_mac_kbd_tb.sv
